/* Makefile */
# Verilator build for the VGA text controller

VERILATOR ?= verilator
TOP       ?= tb_vga_text
RTL_TOP   ?= vga_text_top
SEED      ?= 33
FLAGS     ?= --timing
FILELIST  ?= vga_text_top.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint lint_rtl sim clean

all: sim

# Lint the testbench together with the design
lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Exit status of the model is the pass or fail result
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)

/* include/vga_text_defines.svh */
`ifndef VGA_TEXT_DEFINES_SVH
`define VGA_TEXT_DEFINES_SVH

////////////////////////////////////////////////////////////
// Horizontal timing in dot clocks
////////////////////////////////////////////////////////////
`define H_VISIBLE        10'd640   // Visible dots per line
`define H_SYNC_START     10'd656   // First hsync clock
`define H_SYNC_LEN       10'd96
`define H_TOTAL          10'd800

////////////////////////////////////////////////////////////
// Vertical timing in lines
////////////////////////////////////////////////////////////
`define V_VISIBLE        10'd480
`define V_TEXT_LINES     10'd400   // Lines below this carry text
`define V_SYNC_START     10'd490
`define V_SYNC_LEN       10'd2
`define V_TOTAL          10'd525

// Text geometry and VRAM layout
`define TEXT_COLS        7'd80
`define TEXT_ROWS        5'd25
`define ROW_STRIDE       15'd120   // 80 codes plus 40 attribute bytes
`define VRAM_BASE        15'h7300
`define SCANS_PER_ROW    10'd16    // 8 dot lines, each shown twice

// CRTC commands
`define CMD_CURSOR_LOAD  8'h81
`define CMD_CURSOR_OFF   8'h80
`define CURSOR_ROW_OFF   5'd31     // Never matches a text row

`endif

/* logic/crtc_regs.sv */
`timescale 1ns/10ps
`include "vga_text_defines.svh"

module crtc_regs (
   input  logic                  I_CLK,
   input  logic                  I_RST,
   input  vga_text_pkg::cpu_wr_t cpu_wr,
   output logic                  width80,
   output vga_text_pkg::cursor_t cursor
);

   // Parameter sequence after a cursor load command
   typedef enum logic [1:0] {SEQ_IDLE, SEQ_COL, SEQ_ROW} seq_t;

   vga_text_pkg::cpu_wr_t wr_q;   // Retimed CPU write
   seq_t                  seq;

   ////////////////////////////////////////////////////////////
   // Retiming
   ////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         wr_q <= '0;
      end
      else begin
         wr_q <= cpu_wr;
      end
   end

   ////////////////////////////////////////////////////////////
   // Mode port and cursor registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         seq        <= SEQ_IDLE;
         width80    <= 1'b1;                // 80 columns out of reset
         cursor.col <= '0;
         cursor.row <= `CURSOR_ROW_OFF;
      end
      else begin
         if (wr_q.port_we) width80 <= wr_q.data[0];
         if (wr_q.crtc_we) begin
            if (wr_q.adr) begin                          // Command write
               if (wr_q.data == `CMD_CURSOR_LOAD) seq <= SEQ_COL;
               else                               seq <= SEQ_IDLE;   // Aborts pending params
               if (wr_q.data == `CMD_CURSOR_OFF) cursor.row <= `CURSOR_ROW_OFF;
            end
            else begin                                   // Parameter write
               case (seq)
                  SEQ_COL: begin
                     cursor.col <= wr_q.data[6:0];
                     seq        <= SEQ_ROW;
                  end
                  SEQ_ROW: begin
                     cursor.row <= wr_q.data[4:0];
                     seq        <= SEQ_IDLE;
                  end
                  default: seq <= SEQ_IDLE;             // Stray parameter ignored
               endcase
            end
         end
      end
   end

endmodule

/* logic/row_buffer.sv */
`timescale 1ns/10ps
`include "vga_text_defines.svh"

module row_buffer (
   input  logic                  I_CLK,
   input  vga_text_pkg::buf_wr_t wr,
   input  logic                  rd_bank,
   input  vga_text_pkg::col_t    rd_col,
   output vga_text_pkg::byte_t   rd_data
);

   vga_text_pkg::byte_t mem [0:2*`TEXT_COLS-1];   // Two banks of 80 codes

   // Bank 1 sits right above bank 0
   function automatic logic [7:0] slot(input logic bank, input vga_text_pkg::col_t col);
      return bank ? 8'(col) + 8'(`TEXT_COLS) : 8'(col);
   endfunction

   always_ff @(posedge I_CLK) begin
      if (wr.we) mem[slot(wr.bank, wr.col)] <= wr.data;
      rd_data <= mem[slot(rd_bank, rd_col)];   // Registered read
   end

endmodule

/* logic/row_fetch.sv */
`timescale 1ns/10ps
`include "vga_text_defines.svh"

module row_fetch (
   input  logic                    I_CLK,
   input  logic                    I_RST,
   input  vga_text_pkg::scan_pos_t pos,
   output logic                    vram_req,
   input  logic                    vram_ack,
   output vga_text_pkg::vram_adr_t vram_adr,
   input  vga_text_pkg::byte_t     vram_data,
   output vga_text_pkg::buf_wr_t   buf_wr
);

   // Last line that triggers a row fetch within the text area
   localparam vga_text_pkg::vcnt_t LAST_TRIG_LINE = `SCANS_PER_ROW * (`TEXT_ROWS - 5'd2);

   vga_text_pkg::fetch_state_t state;
   vga_text_pkg::col_t         col;        // Column of the next grant
   logic                       bank;       // Bank being filled
   logic                       trig_top;   // Row 0 of the next frame
   logic                       trig_row;   // Row r+1 while row r shows
   vga_text_pkg::row_t         next_row;
   vga_text_pkg::vram_adr_t    row_base;
   logic                       grant;
   logic                       gnt_q;      // Grant retimed
   vga_text_pkg::col_t         gnt_col;
   logic                       gnt_bank;
   logic                       wr_en;      // Aligned with wr_data
   vga_text_pkg::col_t         wr_col;
   logic                       wr_bank;
   vga_text_pkg::byte_t        wr_data;

   assign trig_top = (pos.h == '0) && (pos.v == `V_VISIBLE);
   assign trig_row = (pos.h == '0) && (pos.v <= LAST_TRIG_LINE)
                     && ((pos.v % `SCANS_PER_ROW) == '0);
   assign next_row = trig_top ? '0
                              : vga_text_pkg::row_t'(pos.v / `SCANS_PER_ROW) + 5'd1;
   assign row_base = `VRAM_BASE + `ROW_STRIDE * vga_text_pkg::vram_adr_t'(next_row);

   assign vram_req = (state == vga_text_pkg::FETCH);
   assign grant    = vram_req & vram_ack;   // Owner took this address

   ////////////////////////////////////////////////////////////
   // Bus request FSM
   ////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         state    <= vga_text_pkg::IDLE;
         vram_adr <= '0;
         col      <= '0;
         bank     <= 1'b0;
      end
      else begin
         case (state)
            vga_text_pkg::IDLE: begin
               if (trig_top || trig_row) begin
                  state    <= vga_text_pkg::FETCH;
                  vram_adr <= row_base;
                  col      <= '0;
                  bank     <= next_row[0];   // Even rows bank 0
               end
            end
            vga_text_pkg::FETCH: begin
               if (vram_ack) begin
                  vram_adr <= vram_adr + 15'd1;
                  col      <= col + 7'd1;
                  if (col == `TEXT_COLS - 7'd1) state <= vga_text_pkg::IDLE;  // 80th grant
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Buffer write alignment
   ////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         gnt_q <= 1'b0;
         wr_en <= 1'b0;
      end
      else begin
         gnt_q <= grant;
         wr_en <= gnt_q;   // Data arrives one clock after grant
      end
   end

   always_ff @(posedge I_CLK) begin
      gnt_col  <= col;
      gnt_bank <= bank;
      wr_col   <= gnt_col;
      wr_bank  <= gnt_bank;
      wr_data  <= vram_data;   // Retimed bus data
   end

   assign buf_wr = '{we: wr_en, bank: wr_bank, col: wr_col, data: wr_data};

endmodule

/* logic/sync_gen.sv */
`timescale 1ns/10ps
`include "vga_text_defines.svh"

module sync_gen (
   input  logic                    I_CLK,
   input  logic                    I_RST,
   output vga_text_pkg::scan_pos_t pos,
   output logic                    hsync_raw,
   output logic                    vsync_raw
);

   vga_text_pkg::hcnt_t hcnt;
   vga_text_pkg::vcnt_t vcnt;
   logic                h_last;   // Last clock of the line
   logic                v_last;   // Last line of the frame

   assign h_last = (hcnt == `H_TOTAL - 10'd1);
   assign v_last = (vcnt == `V_TOTAL - 10'd1);

   ////////////////////////////////////////////////////////////
   // 800 x 525 raster counters
   ////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         hcnt <= '0;
         vcnt <= '0;
      end
      else if (h_last) begin
         hcnt <= '0;
         vcnt <= v_last ? '0 : vcnt + 10'd1;   // Line steps on h wrap
      end
      else begin
         hcnt <= hcnt + 10'd1;
      end
   end

   // Syncs lag the counters by one clock
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         hsync_raw <= 1'b1;
         vsync_raw <= 1'b1;
      end
      else begin
         hsync_raw <= !(hcnt >= `H_SYNC_START && hcnt < `H_SYNC_START + `H_SYNC_LEN);
         vsync_raw <= !(vcnt >= `V_SYNC_START && vcnt < `V_SYNC_START + `V_SYNC_LEN);
      end
   end

   assign pos = '{h: hcnt, v: vcnt};

endmodule

/* logic/text_pixel.sv */
`timescale 1ns/10ps
`include "vga_text_defines.svh"

module text_pixel (
   input  logic                     I_CLK,
   input  logic                     I_RST,
   input  vga_text_pkg::scan_pos_t  pos,
   input  logic                     hsync_raw,
   input  logic                     vsync_raw,
   input  logic                     width80,
   input  vga_text_pkg::cursor_t    cursor,
   output logic                     rd_bank,
   output vga_text_pkg::col_t       rd_col,
   input  vga_text_pkg::byte_t      rd_data,
   output vga_text_pkg::glyph_adr_t glyph_adr,
   input  vga_text_pkg::byte_t      glyph_data,
   output vga_text_pkg::rgb_t       rgb,
   output logic                     hsync,
   output logic                     vsync
);

   // Clocks from scan position to shift register output
   localparam int PIPE = 3;

   vga_text_pkg::col_t  byte_idx;
   vga_text_pkg::row_t  row;
   logic                h_act;        // Inside 640 visible dots
   logic                in_text;      // Inside the text window
   logic                cur_hit;
   logic [2:0]          dline_q;      // Dot line beside rd_data
   logic [3:0]          hlo_q1;
   logic [3:0]          hlo_q2;       // Dot in cell beside glyph_data
   logic                cell_start;
   vga_text_pkg::byte_t shreg;        // Dots of the current cell
   logic [PIPE-1:0]     win_q;
   logic [PIPE-1:0]     cur_q;
   logic [PIPE-1:0]     hs_q;         // Raw syncs are one clock late already
   logic [PIPE-1:0]     vs_q;
   logic                lit;

   ////////////////////////////////////////////////////////////
   // Cell address from the scan position
   ////////////////////////////////////////////////////////////
   assign h_act    = (pos.h < `H_VISIBLE);
   assign in_text  = h_act && (pos.v < `V_TEXT_LINES);
   assign row      = vga_text_pkg::row_t'(pos.v / `SCANS_PER_ROW);
   assign byte_idx = !h_act  ? '0 :
                     width80 ? pos.h[9:3] :        // 8 dots per code
                               {pos.h[9:4], 1'b0};  // Even codes, 16 dots each
   assign cur_hit  = (byte_idx == cursor.col) && (row == cursor.row);

   assign rd_bank   = row[0];
   assign rd_col    = byte_idx;
   assign glyph_adr = {rd_data, dline_q};

   always_ff @(posedge I_CLK) begin
      dline_q <= pos.v[3:1];    // Each dot line on two scanlines
      hlo_q1  <= pos.h[3:0];
      hlo_q2  <= hlo_q1;
   end

   ////////////////////////////////////////////////////////////
   // Dot shifter
   ////////////////////////////////////////////////////////////
   assign cell_start = width80 ? (hlo_q2[2:0] == 3'd0) : (hlo_q2 == 4'd0);

   always_ff @(posedge I_CLK) begin
      if (cell_start)
         shreg <= glyph_data;
      else if (width80 || !hlo_q2[0])      // Every second dot in 40 columns
         shreg <= {shreg[6:0], 1'b0};
   end

   // Window, cursor and sync delay lines
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         win_q <= '0;
         cur_q <= '0;
         hs_q  <= '1;
         vs_q  <= '1;
      end
      else begin
         win_q <= {win_q[PIPE-2:0], in_text};
         cur_q <= {cur_q[PIPE-2:0], cur_hit};
         hs_q  <= {hs_q[PIPE-2:0], hsync_raw};
         vs_q  <= {vs_q[PIPE-2:0], vsync_raw};
      end
   end

   ////////////////////////////////////////////////////////////
   // Output register
   ////////////////////////////////////////////////////////////
   assign lit = win_q[PIPE-1] & (shreg[7] ^ cur_q[PIPE-1]);   // Cursor inverts the cell

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         rgb <= '0;
      end
      else begin
         rgb <= lit ? '{r: 4'hF, g: 4'hF, b: 4'hF} : '0;   // Monochrome white
      end
   end

   assign hsync = hs_q[PIPE-1];
   assign vsync = vs_q[PIPE-1];

endmodule

/* logic/vga_text_pkg.sv */
package vga_text_pkg;

   typedef logic [9:0]  hcnt_t;       // Dot clock within a line
   typedef logic [9:0]  vcnt_t;       // Line within a frame
   typedef logic [14:0] vram_adr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [6:0]  col_t;        // Character column
   typedef logic [4:0]  row_t;        // Text row
   typedef logic [10:0] glyph_adr_t;  // Code then dot line

   // Position of the raster counters
   typedef struct packed {
      hcnt_t h;
      vcnt_t v;
   } scan_pos_t;

   // One CPU bus write
   typedef struct packed {
      logic  port_we;   // Mode port strobe
      logic  crtc_we;   // CRTC strobe
      logic  adr;       // 1 command, 0 parameter
      byte_t data;
   } cpu_wr_t;

   typedef struct packed {
      col_t col;
      row_t row;
   } cursor_t;

   // Row buffer write port
   typedef struct packed {
      logic  we;
      logic  bank;
      col_t  col;
      byte_t data;
   } buf_wr_t;

   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb_t;

   typedef enum logic {IDLE, FETCH} fetch_state_t;

endpackage

/* logic/vga_text_top.sv */
`timescale 1ns/10ps

module vga_text_top (
   input  logic                     I_CLK,
   input  logic                     I_RST,
   input  vga_text_pkg::cpu_wr_t    cpu_wr,
   output logic                     vram_req,
   input  logic                     vram_ack,
   output vga_text_pkg::vram_adr_t  vram_adr,
   input  vga_text_pkg::byte_t      vram_data,
   output vga_text_pkg::glyph_adr_t glyph_adr,
   input  vga_text_pkg::byte_t      glyph_data,
   output vga_text_pkg::rgb_t       rgb,
   output logic                     hsync,
   output logic                     vsync
);

   vga_text_pkg::scan_pos_t pos;
   logic                    hsync_raw;
   logic                    vsync_raw;
   logic                    width80;
   vga_text_pkg::cursor_t   cursor;
   vga_text_pkg::buf_wr_t   buf_wr;
   logic                    rd_bank;
   vga_text_pkg::col_t      rd_col;
   vga_text_pkg::byte_t     rd_data;

   ////////////////////////////////////////////////////////////
   // CPU side and raster timing
   ////////////////////////////////////////////////////////////
   crtc_regs u_crtc_regs (
      .I_CLK   (I_CLK),
      .I_RST   (I_RST),
      .cpu_wr  (cpu_wr),
      .width80 (width80),
      .cursor  (cursor)
   );

   sync_gen u_sync_gen (
      .I_CLK     (I_CLK),
      .I_RST     (I_RST),
      .pos       (pos),
      .hsync_raw (hsync_raw),
      .vsync_raw (vsync_raw)
   );

   ////////////////////////////////////////////////////////////
   // VRAM fetch into the row buffer
   ////////////////////////////////////////////////////////////
   row_fetch u_row_fetch (
      .I_CLK     (I_CLK),
      .I_RST     (I_RST),
      .pos       (pos),
      .vram_req  (vram_req),
      .vram_ack  (vram_ack),
      .vram_adr  (vram_adr),
      .vram_data (vram_data),
      .buf_wr    (buf_wr)
   );

   row_buffer u_row_buffer (
      .I_CLK   (I_CLK),
      .wr      (buf_wr),
      .rd_bank (rd_bank),
      .rd_col  (rd_col),
      .rd_data (rd_data)
   );

   // Pixel pipeline with matched syncs
   text_pixel u_text_pixel (
      .I_CLK      (I_CLK),
      .I_RST      (I_RST),
      .pos        (pos),
      .hsync_raw  (hsync_raw),
      .vsync_raw  (vsync_raw),
      .width80    (width80),
      .cursor     (cursor),
      .rd_bank    (rd_bank),
      .rd_col     (rd_col),
      .rd_data    (rd_data),
      .glyph_adr  (glyph_adr),
      .glyph_data (glyph_data),
      .rgb        (rgb),
      .hsync      (hsync),
      .vsync      (vsync)
   );

endmodule

/* verification/tb_frame_model.sv */
`timescale 1ns/10ps
`include "vga_text_defines.svh"

module tb_frame_model (
   input  logic                    I_CLK,
   input  logic                    I_RST,
   input  logic                    hsync,       // DUT syncs, used once for phase lock
   input  logic                    vsync,
   input  logic                    width80,     // Expected column mode
   input  vga_text_pkg::cursor_t   cursor,      // Expected cursor
   output logic                    locked,
   output vga_text_pkg::scan_pos_t pos,         // Aligned position of rgb
   output vga_text_pkg::rgb_t      exp_rgb,
   output logic                    exp_hsync,
   output logic                    exp_vsync
);

   vga_text_pkg::byte_t vram_img  [0:32767];    // Loaded by the testbench
   vga_text_pkg::byte_t glyph_img [0:2047];
   logic                h_ok;                   // Horizontal phase known
   logic                hs_d;
   logic                vs_d;
   vga_text_pkg::hcnt_t h_next;
   vga_text_pkg::vcnt_t v_next;

   // Pixel rule of the text screen
   function automatic logic lit_at(input vga_text_pkg::scan_pos_t p, input logic w80,
                                   input vga_text_pkg::cursor_t cur);
      vga_text_pkg::row_t       row;
      vga_text_pkg::col_t       idx;
      logic [2:0]               dl;
      logic [2:0]               bitn;
      vga_text_pkg::vram_adr_t  adr;
      vga_text_pkg::byte_t      code;
      vga_text_pkg::byte_t      dots;
      logic                     hit;
      if (p.v >= `V_TEXT_LINES || p.h >= `H_VISIBLE) return 1'b0;   // Black border and lines
      row = vga_text_pkg::row_t'(p.v / 10'd16);
      dl  = 3'((p.v % 10'd16) / 10'd2);    // Dot line shown twice
      if (w80) begin
         idx  = vga_text_pkg::col_t'(p.h / 10'd8);
         bitn = 3'd7 - 3'(p.h % 10'd8);
      end
      else begin
         idx  = vga_text_pkg::col_t'(10'd2 * (p.h / 10'd16));   // Even bytes only
         bitn = 3'd7 - 3'((p.h % 10'd16) / 10'd2);
      end
      adr  = `VRAM_BASE + `ROW_STRIDE * vga_text_pkg::vram_adr_t'(row)
             + vga_text_pkg::vram_adr_t'(idx);
      code = vram_img[adr];
      dots = glyph_img[{code, dl}];
      hit  = (idx == cur.col) && (row == cur.row);
      return dots[bitn] ^ hit;
   endfunction

   assign h_next = (pos.h == `H_TOTAL - 10'd1) ? '0 : pos.h + 10'd1;
   assign v_next = (pos.h != `H_TOTAL - 10'd1) ? pos.v :
                   (pos.v == `V_TOTAL - 10'd1) ? '0 : pos.v + 10'd1;

   ////////////////////////////////////////////////////////////
   // Aligned position, locked on the first sync edges
   ////////////////////////////////////////////////////////////
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         h_ok   <= 1'b0;
         locked <= 1'b0;
         hs_d   <= 1'b1;
         vs_d   <= 1'b1;
         pos    <= '0;
      end
      else begin
         hs_d <= hsync;
         vs_d <= vsync;
         if (!h_ok) begin
            if (hs_d && !hsync) begin          // Ending cycle was h 656
               h_ok  <= 1'b1;
               pos.h <= `H_SYNC_START + 10'd1;
            end
         end
         else if (!locked && vs_d && !vsync) begin
            locked <= 1'b1;
            pos    <= '{h: h_next, v: `V_SYNC_START};   // Line 490 from here on
         end
         else begin
            pos <= '{h: h_next, v: v_next};
         end
      end
   end

   assign exp_rgb   = lit_at(pos, width80, cursor) ? '{r: 4'hF, g: 4'hF, b: 4'hF} : '0;
   assign exp_hsync = !(pos.h >= `H_SYNC_START && pos.h < `H_SYNC_START + `H_SYNC_LEN);
   assign exp_vsync = !(pos.v >= `V_SYNC_START && pos.v < `V_SYNC_START + `V_SYNC_LEN);

endmodule

/* verification/tb_vga_text.sv */
`timescale 1ns/10ps
`include "vga_text_defines.svh"

module tb_vga_text;

   localparam int FRAME_CLKS = int'(`H_TOTAL) * int'(`V_TOTAL);

   logic                     I_CLK;
   logic                     I_RST;
   vga_text_pkg::cpu_wr_t    cpu_wr;
   logic                     vram_req;
   logic                     vram_ack;
   vga_text_pkg::vram_adr_t  vram_adr;
   vga_text_pkg::byte_t      vram_data;
   vga_text_pkg::glyph_adr_t glyph_adr;
   vga_text_pkg::byte_t      glyph_data;
   vga_text_pkg::rgb_t       rgb;
   logic                     hsync;
   logic                     vsync;
   logic                     locked;
   vga_text_pkg::scan_pos_t  mpos;         // Model position of rgb
   vga_text_pkg::rgb_t       exp_rgb;
   logic                     exp_hsync;
   logic                     exp_vsync;
   logic                     exp_width80;
   vga_text_pkg::cursor_t    exp_cursor;
   vga_text_pkg::vram_adr_t  adr_seen;     // Address of the previous cycle
   vga_text_pkg::glyph_adr_t gadr_seen;
   int                       misses;       // Cycles since the last grant
   int                       grants;
   int                       fetch_row;
   logic                     req_was;
   logic                     checking;
   int                       frames_checked;
   int unsigned              seed_val;
   vga_text_pkg::col_t       cur_col;
   vga_text_pkg::row_t       cur_row;

   vga_text_top u_dut (
      .I_CLK(I_CLK), .I_RST(I_RST), .cpu_wr(cpu_wr),
      .vram_req(vram_req), .vram_ack(vram_ack), .vram_adr(vram_adr), .vram_data(vram_data),
      .glyph_adr(glyph_adr), .glyph_data(glyph_data),
      .rgb(rgb), .hsync(hsync), .vsync(vsync)
   );

   tb_frame_model u_model (
      .I_CLK(I_CLK), .I_RST(I_RST), .hsync(hsync), .vsync(vsync),
      .width80(exp_width80), .cursor(exp_cursor), .locked(locked), .pos(mpos),
      .exp_rgb(exp_rgb), .exp_hsync(exp_hsync), .exp_vsync(exp_vsync)
   );

   always #2 I_CLK = ~I_CLK;   // 4 ns dot clock

   ////////////////////////////////////////////////////////////
   // Failure reporting and compares
   ////////////////////////////////////////////////////////////
   task automatic abort_run();
      $display("Simulation FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_adr(input string name, input vga_text_pkg::vram_adr_t exp,
                            input vga_text_pkg::vram_adr_t act);
      if (act !== exp) begin
         $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_rgb(input string name, input vga_text_pkg::rgb_t exp,
                            input vga_text_pkg::rgb_t act);
      if (act !== exp) begin
         $display("Fail at %0t: %s expected %h got %h (h %0d v %0d)",
                  $time, name, exp, act, mpos.h, mpos.v);
         abort_run();
      end
   endtask

   task automatic check_sync(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   // One-cycle CPU strobe, port or CRTC
   task automatic cpu_write(input logic to_port, input logic adr, input vga_text_pkg::byte_t data);
      @(posedge I_CLK);
      #1;
      cpu_wr = '{port_we: to_port, crtc_we: !to_port, adr: adr, data: data};
      @(posedge I_CLK);
      #1;
      cpu_wr = '0;
   endtask

   task automatic wait_pos(input vga_text_pkg::hcnt_t h, input vga_text_pkg::vcnt_t v,
                           input int limit, input string what);
      int n;
      for (n = 0; n < limit && !(locked && mpos.h == h && mpos.v == v); n++)
         @(negedge I_CLK);
      if (!(locked && mpos.h == h && mpos.v == v)) begin
         $display("Error: timed out waiting for %s", what);
         abort_run();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // VRAM owner, glyph ROM and fetch monitor
   ////////////////////////////////////////////////////////////
   always @(posedge I_CLK) begin
      #1;
      vram_data  = u_model.vram_img[adr_seen];     // One cycle read latency
      glyph_data = u_model.glyph_img[gadr_seen];
      adr_seen   = vram_adr;
      gadr_seen  = glyph_adr;
      if (vram_req) begin
         vram_ack = (misses == 3) ? 1'b1 : 1'($urandom % 2);   // At least one grant in four
         misses   = vram_ack ? 0 : misses + 1;
      end
      else begin
         vram_ack = 1'b0;
         misses   = 0;
      end
      if (vram_req && !req_was) grants = 0;        // New row fetch
      if (vram_req && vram_ack) begin
         if (grants == int'(`TEXT_COLS)) begin
            $display("Error: fetch of row %0d took more than 80 grants", fetch_row);
            abort_run();
         end
         check_adr("vram_adr", `VRAM_BASE + `ROW_STRIDE * vga_text_pkg::vram_adr_t'(fetch_row)
                   + vga_text_pkg::vram_adr_t'(grants), vram_adr);
         grants++;
      end
      if (!vram_req && req_was) begin
         if (grants != int'(`TEXT_COLS)) begin
            $display("Error: fetch of row %0d ended after %0d grants", fetch_row, grants);
            abort_run();
         end
         fetch_row = (fetch_row + 1) % int'(`TEXT_ROWS);   // Rows 0 to 24 in turn
      end
      req_was = vram_req;
   end

   // Outputs compared mid-cycle once the model is locked
   always @(negedge I_CLK) begin
      if (!I_RST && locked) begin
         check_sync("hsync", exp_hsync, hsync);
         check_sync("vsync", exp_vsync, vsync);
         if (mpos.h == '0 && mpos.v == '0) checking = 1'b1;   // First full frame
         if (checking) begin
            check_rgb("rgb", exp_rgb, rgb);
            if (mpos.h == `H_TOTAL - 10'd1 && mpos.v == `V_TOTAL - 10'd1) frames_checked++;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      I_CLK = 1'b0;
      I_RST = 1'b1;
      cpu_wr = '0;
      vram_ack = 1'b0;
      vram_data = '0;
      glyph_data = '0;
      adr_seen = '0;
      gadr_seen = '0;
      misses = 0;
      grants = 0;
      fetch_row = 1;            // Line 0 right after reset triggers row 1
      req_was = 1'b0;
      checking = 1'b0;
      frames_checked = 0;
      exp_width80 = 1'b1;
      exp_cursor = '{col: '0, row: `CURSOR_ROW_OFF};
      seed_val = $urandom(33);
      for (int i = 0; i < 32768; i++) u_model.vram_img[i] = vga_text_pkg::byte_t'($urandom);
      for (int i = 0; i < 2048; i++) u_model.glyph_img[i] = vga_text_pkg::byte_t'($urandom);

      repeat (10) @(posedge I_CLK);
      #1;
      check_sync("vram_req", 1'b0, vram_req);     // Reset state
      check_rgb("rgb", '0, rgb);
      check_sync("hsync", 1'b1, hsync);
      check_sync("vsync", 1'b1, vsync);
      I_RST = 1'b0;

      // Frame 1 in 80 columns, no cursor
      wait_pos('0, '0, 2 * FRAME_CLKS, "first full frame");
      wait_pos('0, `V_TEXT_LINES, FRAME_CLKS, "blanking after frame 1");
      cpu_write(1'b1, 1'b0, 8'h00);
      exp_width80 = 1'b0;

      // Frame 2 in 40 columns
      wait_pos('0, '0, FRAME_CLKS, "start of frame 2");
      wait_pos('0, `V_TEXT_LINES, FRAME_CLKS, "blanking after frame 2");
      cur_col = vga_text_pkg::col_t'($urandom % 80);
      cur_row = vga_text_pkg::row_t'($urandom % 25);
      cpu_write(1'b1, 1'b0, 8'h01);
      cpu_write(1'b0, 1'b1, `CMD_CURSOR_LOAD);
      cpu_write(1'b0, 1'b0, {1'b0, cur_col});
      cpu_write(1'b0, 1'b0, {3'b000, cur_row});
      exp_width80 = 1'b1;
      exp_cursor = '{col: cur_col, row: cur_row};

      // Frame 3 with the cursor cell inverted
      wait_pos('0, '0, FRAME_CLKS, "start of frame 3");
      wait_pos('0, `V_TEXT_LINES, FRAME_CLKS, "blanking after frame 3");
      cpu_write(1'b0, 1'b1, `CMD_CURSOR_OFF);
      exp_cursor.row = `CURSOR_ROW_OFF;

      // Frame 4 with the cursor off
      wait_pos('0, '0, FRAME_CLKS, "start of frame 4");
      wait_pos(`H_TOTAL - 10'd1, `V_TOTAL - 10'd1, FRAME_CLKS + 10, "end of frame 4");
      @(posedge I_CLK);
      #1;
      if (frames_checked == 4) begin
         $display("Simulation PASSED");
         $finish;
      end
      else begin
         $display("Error: %0d frames were checked instead of 4", frames_checked);
         abort_run();
      end
   end

endmodule

/* vga_text_top.f */
+incdir+include
logic/vga_text_pkg.sv
logic/crtc_regs.sv
logic/sync_gen.sv
logic/row_fetch.sv
logic/row_buffer.sv
logic/text_pixel.sv
logic/vga_text_top.sv
verification/tb_frame_model.sv
verification/tb_vga_text.sv
